// ==== hdl/axi_burst_addr.sv ====
module axi_burst_addr (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  cbus_pkg::addr_t     start_addr,
    input  axi_pkg::axi_len_t   len,
    input  axi_pkg::axi_burst_t burst,
    input  logic                step,
    output cbus_pkg::addr_t     beat_addr
);

    cbus_pkg::addr_t wrap_mask;
    cbus_pkg::addr_t incr_addr;
    cbus_pkg::addr_t next_addr;

    // byte offset mask of the (len+1)*4 window, exact for 1, 2 and 4 beats
    assign wrap_mask = cbus_pkg::addr_t'({len, 2'b11});
    assign incr_addr = beat_addr + 32'd4;

    always_comb begin
        case (burst)
            axi_pkg::burst_incr: next_addr = incr_addr;
            // upper bits stay, the offset rolls over inside the window
            axi_pkg::burst_wrap: next_addr = (beat_addr & ~wrap_mask) | (incr_addr & wrap_mask);
            default:             next_addr = beat_addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            beat_addr <= '0;
        end else if (start) begin
            beat_addr <= start_addr;
        end else if (step) begin
            beat_addr <= next_addr;
        end
    end

endmodule

// ==== hdl/axi_if.sv ====
interface axi_if;

    // read address
    logic                ar_valid;
    logic                ar_ready;
    cbus_pkg::addr_t     ar_addr;
    axi_pkg::axi_len_t   ar_len;
    axi_pkg::axi_size_t  ar_size;
    axi_pkg::axi_burst_t ar_burst;

    // read data
    logic                r_valid;
    logic                r_ready;
    cbus_pkg::word_t     r_data;
    logic                r_last;

    // write address
    logic                aw_valid;
    logic                aw_ready;
    cbus_pkg::addr_t     aw_addr;
    axi_pkg::axi_len_t   aw_len;
    axi_pkg::axi_size_t  aw_size;
    axi_pkg::axi_burst_t aw_burst;

    // write data
    logic                w_valid;
    logic                w_ready;
    cbus_pkg::word_t     w_data;
    axi_pkg::axi_strb_t  w_strb;
    logic                w_last;

    // write response, always okay
    logic                b_valid;
    logic                b_ready;

    modport manager (
        output ar_valid, ar_addr, ar_len, ar_size, ar_burst, input ar_ready,
        input  r_valid, r_data, r_last, output r_ready,
        output aw_valid, aw_addr, aw_len, aw_size, aw_burst, input aw_ready,
        output w_valid, w_data, w_strb, w_last, input w_ready,
        input  b_valid, output b_ready
    );

    modport subordinate (
        input  ar_valid, ar_addr, ar_len, ar_size, ar_burst, output ar_ready,
        output r_valid, r_data, r_last, input r_ready,
        input  aw_valid, aw_addr, aw_len, aw_size, aw_burst, output aw_ready,
        input  w_valid, w_data, w_strb, w_last, output w_ready,
        output b_valid, input b_ready
    );

endinterface

// ==== hdl/axi_mem_slave.sv ====
module axi_mem_slave #(
    parameter int mem_words = 1024
) (
    input logic        clk,
    input logic        resetn,
    axi_if.subordinate axi
);

    localparam int idx_bits  = $clog2(mem_words);
    localparam int strb_bits = $bits(axi_pkg::axi_strb_t);

    typedef enum logic [1:0] {
        idle,
        read_data,
        write_data,
        write_resp
    } state_t;

    state_t              state;
    cbus_pkg::word_t     mem [mem_words];

    axi_pkg::axi_len_t   len_q;
    axi_pkg::axi_burst_t burst_q;
    axi_pkg::axi_len_t   beat_cnt;

    cbus_pkg::addr_t     start_addr;
    cbus_pkg::addr_t     beat_addr;
    logic [idx_bits-1:0] word_idx;

    logic ar_take;
    logic aw_take;
    logic r_beat;
    logic w_beat;

    // one transaction at a time, reads win if both show up
    assign axi.ar_ready = state == idle;
    assign axi.aw_ready = state == idle && !axi.ar_valid;

    assign ar_take = axi.ar_valid && axi.ar_ready;
    assign aw_take = axi.aw_valid && axi.aw_ready;

    assign axi.r_valid = state == read_data;
    assign axi.w_ready = state == write_data;
    assign axi.b_valid = state == write_resp;

    assign r_beat = axi.r_valid && axi.r_ready;
    assign w_beat = axi.w_valid && axi.w_ready;

    assign start_addr = ar_take ? axi.ar_addr : axi.aw_addr;

    axi_burst_addr u_burst_addr (
        .clk        (clk),
        .resetn     (resetn),
        .start      (ar_take || aw_take),
        .start_addr (start_addr),
        .len        (len_q),
        .burst      (burst_q),
        .step       (r_beat || w_beat),
        .beat_addr  (beat_addr)
    );

    assign word_idx   = beat_addr[2 +: idx_bits];
    assign axi.r_data = mem[word_idx];
    assign axi.r_last = beat_cnt == len_q;

    // burst shape is captured with the address
    always_ff @(posedge clk) begin
        if (ar_take) begin
            len_q   <= axi.ar_len;
            burst_q <= axi.ar_burst;
        end else if (aw_take) begin
            len_q   <= axi.aw_len;
            burst_q <= axi.aw_burst;
        end
    end

    always_ff @(posedge clk) begin
        if (w_beat) begin
            for (int i = 0; i < strb_bits; i++) begin
                if (axi.w_strb[i]) begin
                    mem[word_idx][8*i +: 8] <= axi.w_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state    <= idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    beat_cnt <= '0;
                    if (ar_take) begin
                        state <= read_data;
                    end else if (aw_take) begin
                        state <= write_data;
                    end
                end

                read_data: begin
                    if (r_beat) begin
                        if (axi.r_last) begin
                            state <= idle;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end

                // manager marks the end of the write burst
                write_data: begin
                    if (w_beat && axi.w_last) begin
                        state <= write_resp;
                    end
                end

                write_resp: begin
                    if (axi.b_ready) begin
                        state <= idle;
                    end
                end

                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== hdl/axi_pkg.sv ====
package axi_pkg;

    // bursts of at most 4 beats
    localparam int axi_len_bits = 2;

    // beat count minus one
    typedef logic [axi_len_bits-1:0] axi_len_t;

    // log2 of bytes per beat, always 2 here
    typedef logic [2:0] axi_size_t;

    // burst encodings as on the AxBURST lines
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_t;

    // one strobe bit per data byte
    typedef logic [3:0] axi_strb_t;

    // all bytes written, no narrow or partial beats
    localparam axi_strb_t axi_full_strobe = '1;

endpackage

// ==== hdl/cbus_axi_bridge.sv ====
module cbus_axi_bridge #(
    parameter bit burst_wrap = 1'b1
) (
    input logic    clk,
    input logic    resetn,
    cbus_if.bridge cbus,
    axi_if.manager axi
);

    localparam int len_bits   = cbus_pkg::cbus_len_bits;
    localparam int round_bits = len_bits - axi_pkg::axi_len_bits;

    localparam axi_pkg::axi_burst_t burst_type =
        burst_wrap ? axi_pkg::burst_wrap : axi_pkg::burst_incr;

    // 4 bytes per beat
    localparam axi_pkg::axi_size_t word_size = 3'd2;

    typedef enum logic [1:0] {
        idle,
        transfer,
        request,
        waiting
    } state_t;

    state_t                state;
    cbus_pkg::addr_t       current_addr;
    logic [round_bits-1:0] round_cnt;
    axi_pkg::axi_len_t     len_cnt;

    logic [len_bits:0]     num_words;
    logic [round_bits-1:0] num_round;
    axi_pkg::axi_len_t     axi_len;
    cbus_pkg::addr_t       addr_step;
    cbus_pkg::addr_t       req_addr;

    logic addr_phase;
    logic addr_ok;
    logic rw_handshake;
    logic resp_ok;
    logic is_last;
    logic is_final;

    // words - 1 splits into rounds - 1 (upper bits) and beats - 1 (lower bits)
    assign num_words = (len_bits + 1)'(1) << cbus.order;
    assign {num_round, axi_len} = len_bits'(num_words - 1'b1);

    // each round starts one full burst further on
    assign addr_step = cbus_pkg::addr_t'({1'b0, axi_len} + 3'd1) << 2;

    assign is_last  = len_cnt == '0;
    assign is_final = is_last && round_cnt == '0;

    // only one of AR and AW is ever requested, so either ready will do
    assign addr_ok      = cbus.is_write ? axi.aw_ready : axi.ar_ready;
    // slave only raises these while we are in transfer
    assign rw_handshake = axi.w_ready || axi.r_valid;
    assign resp_ok      = axi.b_valid;

    // the final write beat of a burst is reported once B arrives
    assign cbus.okay  = (cbus.is_write && is_last) ? resp_ok : rw_handshake;
    assign cbus.last  = is_final && cbus.okay;
    assign cbus.rdata = axi.r_data;

    // address channels
    assign addr_phase = (state == idle && cbus.valid) || state == request;
    assign req_addr   = (state == idle) ? cbus.addr : current_addr;

    assign axi.ar_valid = addr_phase && !cbus.is_write;
    assign axi.ar_addr  = req_addr;
    assign axi.ar_len   = axi_len;
    assign axi.ar_size  = word_size;
    assign axi.ar_burst = burst_type;

    assign axi.aw_valid = addr_phase && cbus.is_write;
    assign axi.aw_addr  = req_addr;
    assign axi.aw_len   = axi_len;
    assign axi.aw_size  = word_size;
    assign axi.aw_burst = burst_type;

    // data and response channels
    assign axi.w_valid = state == transfer && cbus.is_write;
    assign axi.w_data  = cbus.wdata;
    assign axi.w_strb  = axi_pkg::axi_full_strobe;
    assign axi.w_last  = is_last;

    assign axi.r_ready = state == transfer && !cbus.is_write;
    assign axi.b_ready = state == waiting;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state        <= idle;
            current_addr <= '0;
            round_cnt    <= '0;
            len_cnt      <= '0;
        end else begin
            case (state)
                idle: begin
                    if (cbus.valid && addr_ok) begin
                        state        <= transfer;
                        current_addr <= cbus.addr;
                        round_cnt    <= num_round;
                        len_cnt      <= axi_len;
                    end
                end

                transfer: begin
                    if (rw_handshake) begin
                        if (is_final) begin
                            state <= cbus.is_write ? waiting : idle;
                        end else if (is_last) begin
                            state        <= cbus.is_write ? waiting : request;
                            current_addr <= current_addr + addr_step;
                        end else begin
                            len_cnt <= len_cnt - 1'b1;
                        end
                    end
                end

                request: begin
                    if (addr_ok) begin
                        state     <= transfer;
                        round_cnt <= round_cnt - 1'b1;
                        len_cnt   <= axi_len;
                    end
                end

                waiting: begin
                    if (resp_ok) begin
                        state <= is_final ? idle : request;
                    end
                end

                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== hdl/cbus_axi_top.sv ====
module cbus_axi_top #(
    parameter bit burst_wrap = 1'b1,
    parameter int mem_words  = 1024
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  valid,
    input  logic                  is_write,
    input  cbus_pkg::addr_t       addr,
    input  cbus_pkg::cbus_order_t order,
    input  cbus_pkg::word_t       wdata,
    output logic                  okay,
    output logic                  last,
    output cbus_pkg::word_t       rdata
);

    cbus_if cbus ();
    axi_if  axi ();

    // cache bus pins onto the interface
    assign cbus.valid    = valid;
    assign cbus.is_write = is_write;
    assign cbus.addr     = addr;
    assign cbus.order    = order;
    assign cbus.wdata    = wdata;

    assign okay  = cbus.okay;
    assign last  = cbus.last;
    assign rdata = cbus.rdata;

    cbus_axi_bridge #(
        .burst_wrap (burst_wrap)
    ) u_bridge (
        .clk    (clk),
        .resetn (resetn),
        .cbus   (cbus),
        .axi    (axi)
    );

    axi_mem_slave #(
        .mem_words (mem_words)
    ) u_mem (
        .clk    (clk),
        .resetn (resetn),
        .axi    (axi)
    );

endmodule

// ==== hdl/cbus_if.sv ====
interface cbus_if;

    // request side, held by the requester until last
    logic                  valid;
    logic                  is_write;
    cbus_pkg::addr_t       addr;
    cbus_pkg::cbus_order_t order;
    cbus_pkg::word_t       wdata;

    // one okay pulse per word, last with the final one
    logic                  okay;
    logic                  last;
    cbus_pkg::word_t       rdata;

    modport requester (
        output valid, is_write, addr, order, wdata,
        input  okay, last, rdata
    );

    modport bridge (
        input  valid, is_write, addr, order, wdata,
        output okay, last, rdata
    );

endinterface

// ==== hdl/cbus_pkg.sv ====
package cbus_pkg;

    // byte address on both sides of the bridge
    typedef logic [31:0] addr_t;

    // one data word, the cache bus and AXI share this width
    typedef logic [31:0] word_t;

    // log2 of the transfer length in words, 0 to 4 in use
    typedef logic [2:0] cbus_order_t;

    // width of (word count - 1) for a transfer of up to 16 words
    localparam int cbus_len_bits = 4;

endpackage

// ==== run.sh ====
#!/bin/sh
# builds and runs the testbench once with WRAP bursts and once with INCR bursts

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project root"
    exit 1
fi

status=0

for wrap in 1 0; do
    mdir="obj_dir_wrap$wrap"
    echo "building with burst_wrap=$wrap"
    verilator --binary --timing -f src.f --top-module tb_top \
        -Gburst_wrap=$wrap --Mdir "$mdir"
    if [ $? -ne 0 ]; then
        echo "build failed for burst_wrap=$wrap"
        exit 1
    fi

    output=$("./$mdir/Vtb_top")
    run_status=$?
    echo "$output"
    if [ $run_status -ne 0 ]; then
        echo "simulation exited with status $run_status for burst_wrap=$wrap"
        status=1
    fi

    echo "$output" | grep -q "^Result: PASSED$"
    if [ $? -ne 0 ]; then
        echo "burst_wrap=$wrap did not pass"
        status=1
    fi
done

exit $status

// ==== src.f ====
hdl/cbus_pkg.sv
hdl/axi_pkg.sv
hdl/cbus_if.sv
hdl/axi_if.sv
hdl/axi_burst_addr.sv
hdl/cbus_axi_bridge.sv
hdl/axi_mem_slave.sv
hdl/cbus_axi_top.sv
verification/cbus_checker.sv
verification/tb_top.sv

// ==== verification/cbus_checker.sv ====
module cbus_checker #(
    parameter bit burst_wrap = 1'b1,
    parameter int mem_words  = 1024
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  valid,
    input  logic                  is_write,
    input  cbus_pkg::addr_t       addr,
    input  cbus_pkg::cbus_order_t order,
    input  cbus_pkg::word_t       wdata,
    input  logic                  okay,
    input  logic                  last,
    input  cbus_pkg::word_t       rdata,
    output int                    data_errors,
    output int                    protocol_errors
);

    // what the memory should hold, built from the writes seen on the bus
    cbus_pkg::word_t shadow [mem_words];

    // okay pulses so far in the current transfer
    int word_cnt;

    // byte address of word k of a transfer
    function automatic cbus_pkg::addr_t expected_addr(input cbus_pkg::addr_t base,
                                                      input int ord, input int k,
                                                      input bit wrap);
        int              blen;
        cbus_pkg::addr_t round_start;
        cbus_pkg::addr_t window;
        cbus_pkg::addr_t beat_addr;
        blen        = (ord >= 2) ? 4 : (1 << ord);
        round_start = base + cbus_pkg::addr_t'((k / 4) * blen * 4);
        beat_addr   = round_start + cbus_pkg::addr_t'((k % 4) * 4);
        window      = cbus_pkg::addr_t'(blen * 4);
        // wrap inside the window aligned to the burst size
        if (wrap) begin
            beat_addr = (round_start & ~(window - 1)) | (beat_addr & (window - 1));
        end
        return beat_addr;
    endfunction

    // memory only decodes the low address bits, so it aliases
    function automatic int shadow_index(input cbus_pkg::addr_t a);
        return int'(a >> 2) % mem_words;
    endfunction

    always @(posedge clk) begin
        int              words;
        int              idx;
        cbus_pkg::addr_t exp_addr;
        if (resetn) begin
            word_cnt        = 0;
            data_errors     = 0;
            protocol_errors = 0;
        end else if (!valid) begin
            word_cnt = 0;
            if (okay || last) begin
                $display("okay or last was raised with no request pending at time %0t",
                         $time);
                protocol_errors = protocol_errors + 1;
            end
        end else if (okay) begin
            words    = 1 << order;
            exp_addr = expected_addr(addr, int'(order), word_cnt, burst_wrap);
            idx      = shadow_index(exp_addr);
            if (is_write) begin
                shadow[idx] = wdata;
            end else if (rdata !== shadow[idx]) begin
                $display("** Error at time %0t: read word %0d at %h returned %h, expected %h",
                         $time, word_cnt, exp_addr, rdata, shadow[idx]);
                data_errors = data_errors + 1;
            end
            if (last && word_cnt != words - 1) begin
                $display("last came early, on word %0d of %0d at time %0t",
                         word_cnt + 1, words, $time);
                protocol_errors = protocol_errors + 1;
            end else if (!last && word_cnt >= words - 1) begin
                $display("last is missing after word %0d of %0d at time %0t",
                         word_cnt + 1, words, $time);
                protocol_errors = protocol_errors + 1;
            end
            word_cnt = last ? 0 : word_cnt + 1;
        end else if (last) begin
            $display("last was raised without okay at time %0t", $time);
            protocol_errors = protocol_errors + 1;
        end
    end

endmodule

// ==== verification/tb_top.sv ====
module tb_top #(
    parameter bit burst_wrap = 1'b1
);

    localparam int mem_words = 1024;

    // transfers per test group, these size the watchdog
    localparam int fill_count      = mem_words / 16;
    localparam int aligned_count   = 5 + 31;
    localparam int burst_count     = 5;
    localparam int unaligned_count = 4 * 22;
    localparam int random_count    = 200;
    localparam int num_transfers   = fill_count + aligned_count + burst_count +
                                     unaligned_count + random_count;
    localparam int timeout_cycles  = num_transfers * 200;

    logic                  clk;
    logic                  resetn;
    logic                  valid;
    logic                  is_write;
    cbus_pkg::addr_t       addr;
    cbus_pkg::cbus_order_t order;
    cbus_pkg::word_t       wdata;
    logic                  okay;
    logic                  last;
    cbus_pkg::word_t       rdata;
    int                    data_errors;
    int                    protocol_errors;

    cbus_axi_top #(
        .burst_wrap (burst_wrap),
        .mem_words  (mem_words)
    ) DUT (
        .clk      (clk),
        .resetn   (resetn),
        .valid    (valid),
        .is_write (is_write),
        .addr     (addr),
        .order    (order),
        .wdata    (wdata),
        .okay     (okay),
        .last     (last),
        .rdata    (rdata)
    );

    cbus_checker #(
        .burst_wrap (burst_wrap),
        .mem_words  (mem_words)
    ) u_checker (
        .clk             (clk),
        .resetn          (resetn),
        .valid           (valid),
        .is_write        (is_write),
        .addr            (addr),
        .order           (order),
        .wdata           (wdata),
        .okay            (okay),
        .last            (last),
        .rdata           (rdata),
        .data_errors     (data_errors),
        .protocol_errors (protocol_errors)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // one cache transfer, request held until last
    task automatic run_transfer(input logic wr, input cbus_pkg::addr_t a, input int ord);
        cbus_pkg::word_t data [16];
        int              k;
        for (k = 0; k < 16; k++) begin
            data[k] = $urandom;
        end
        k = 0;
        @(posedge clk);
        valid    <= 1'b1;
        is_write <= wr;
        addr     <= a;
        order    <= cbus_pkg::cbus_order_t'(ord);
        wdata    <= data[0];
        do begin
            @(posedge clk);
            // next write word shows up the cycle after okay
            if (okay && k < 15) begin
                k = k + 1;
                wdata <= data[k];
            end
        end while (!(okay && last));
        valid <= 1'b0;
    endtask

    // single-word reads over a range of words
    task automatic read_back(input cbus_pkg::addr_t a, input int count);
        for (int i = 0; i < count; i++) begin
            run_transfer(1'b0, a + cbus_pkg::addr_t'(4 * i), 0);
        end
    endtask

    initial begin
        cbus_pkg::addr_t base;
        cbus_pkg::addr_t start;
        logic            wr;
        int              ord;
        void'($urandom(44578));
        resetn   = 1'b1;
        valid    = 1'b0;
        is_write = 1'b0;
        addr     = '0;
        order    = '0;
        wdata    = '0;
        repeat (3) @(posedge clk);
        resetn <= 1'b0;
        // bus has to stay quiet with no request
        repeat (8) @(posedge clk);

        // every word gets a known value first
        for (int i = 0; i < fill_count; i++) begin
            run_transfer(1'b1, cbus_pkg::addr_t'(i * 64), 4);
        end

        for (int o = 0; o <= 4; o++) begin
            base = cbus_pkg::addr_t'(32'h100 + o * 64);
            run_transfer(1'b1, base, o);
            read_back(base, 1 << o);
        end

        for (int o = 0; o <= 4; o++) begin
            run_transfer(1'b0, cbus_pkg::addr_t'(32'h600 + o * 64), o);
        end

        // start in the middle of a burst window
        for (int o = 1; o <= 4; o++) begin
            base  = cbus_pkg::addr_t'(32'ha00 + o * 128);
            start = base + ((o == 1) ? 32'd4 : 32'd12);
            run_transfer(1'b1, start, o);
            run_transfer(1'b0, start, o);
            read_back(base, 20);
        end

        for (int i = 0; i < random_count; i++) begin
            wr  = ($urandom % 2) == 1;
            ord = int'($urandom % 5);
            run_transfer(wr, cbus_pkg::addr_t'(($urandom % mem_words) * 4), ord);
        end

        repeat (2) @(posedge clk);
        $display("errors: %0d data, %0d protocol", data_errors, protocol_errors);
        if (data_errors == 0 && protocol_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule
